/* tcp_snd.f */
+incdir+include
verilog/tcp_snd_pkg.sv
verilog/seg_desc_if.sv
verilog/snd_buffer.sv
verilog/snd_window_ctrl.sv
verilog/seg_emitter.sv
verilog/tcp_snd.sv
sim/tb_tcp_snd.sv

/* build_sim.sh */
#!/bin/sh
# Compile and run the tcp_snd testbench with Verilator.
# Run from the project root. Exits non-zero on any failure.

LOG=sim_run.log

verilator --binary --timing --assert -Wno-fatal \
	-f tcp_snd.f --top-module tb_tcp_snd -o tb_tcp_snd
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/tb_tcp_snd > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

/* sim/tb_tcp_snd.sv */
// Random traffic against a model of the send buffer and window
// Acks only cover words whose payload the link has fully received
// Stale and beyond-range acks are far enough out to be rejected in any state
`timescale 1ns/1ps
`include "tcp_snd_settings.svh"

module tb_tcp_snd;
	import tcp_snd_pkg::*;

	localparam int WAIT_LIMIT = 3000;

	logic  clk;
	logic  rst_n;
	logic  usr_val;
	data_t usr_data;
	logic  usr_credit;
	logic  ack_val;
	seq_t  ack_seq;
	seq_t  ack_wnd;
	logic  seg_val;
	seq_t  seg_seq;
	len_t  seg_len;
	logic  pay_val;
	data_t pay_data;
	logic  seg_credit;

	logic [31:0] lfsr;
	data_t       model_mem [2**`SEQ_W];
	seq_t        wr_model;
	seq_t        model_una;
	seq_t        model_nxt;
	seq_t        sent_seq;
	seq_t        pay_seq;
	seq_t        right_edge;
	int          pay_left;
	int          user_cred;
	int          pulses_seen;
	int          freed_total;
	int          link_owed;
	int          link_wait;
	int          hdr_count;
	int          errors;
	int          tests_failed;
	bit          user_on;
	bit          ack_on;
	bit          link_hold;
	bit          zero_wnd;

	tcp_snd i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.usr_val    (usr_val),
		.usr_data   (usr_data),
		.usr_credit (usr_credit),
		.ack_val    (ack_val),
		.ack_seq    (ack_seq),
		.ack_wnd    (ack_wnd),
		.seg_val    (seg_val),
		.seg_seq    (seg_seq),
		.seg_len    (seg_len),
		.pay_val    (pay_val),
		.pay_data   (pay_data),
		.seg_credit (seg_credit)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Galois LFSR, one step per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'hA3000000;
		end
		return b;
	endfunction

	function automatic int rand_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_bit());
		end
		return v;
	endfunction

	task automatic value_error(string name, int got, int exp);
		$display("FAILED %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic plain_error(string msg);
		$display("ERROR %s", msg);
		errors++;
	endtask

	// Drive one ack and apply the acceptance rule to the model
	task automatic send_ack(seq_t s, seq_t w);
		seq_t ne;
		ack_val <= 1'b1;
		ack_seq <= s;
		ack_wnd <= w;
		if (seq_t'(s - model_una) <= seq_t'(model_nxt - model_una)) begin
			freed_total += int'(seq_t'(s - model_una));
			model_una = s;
			ne = seq_t'(s + w);
			// Right edge only moves forward, a shrunk window may still hold issued segments
			if (seq_t'(right_edge - s) >= 128 || seq_t'(ne - s) > seq_t'(right_edge - s)) begin
				right_edge = ne;
			end
			zero_wnd = (w == '0);
		end
	endtask

	task automatic random_ack();
		int   kind;
		int   span;
		seq_t s;
		kind = rand_bits(3);
		if (kind == 0) begin
			s = seq_t'(model_una - 1 - seq_t'(rand_bits(3)));
			send_ack(s, seq_t'(`INIT_WND));
		end else if (kind == 1) begin
			s = seq_t'(model_una + 20 + seq_t'(rand_bits(3)));
			send_ack(s, seq_t'(`INIT_WND));
		end else begin
			span = int'(seq_t'(sent_seq - model_una));
			s = seq_t'(model_una + seq_t'(rand_bits(5) % (span + 1)));
			send_ack(s, seq_t'(1 + rand_bits(3)));
		end
	endtask

	// Check outputs sampled at this edge
	task automatic monitor();
		bit in_pay;
		in_pay = (pay_left > 0);
		if (usr_credit) begin
			pulses_seen++;
			user_cred++;
			if (pulses_seen > freed_total) begin
				plain_error("usr_credit returned for a word that was never freed");
			end
		end
		if (in_pay) begin
			if (!pay_val) begin
				plain_error("payload beat missing after header");
			end else if (pay_data != model_mem[pay_seq]) begin
				value_error("pay_data", int'(pay_data), int'(model_mem[pay_seq]));
			end
			pay_seq = seq_t'(pay_seq + 1);
			pay_left--;
			if (pay_left == 0) begin
				sent_seq = pay_seq;
			end
		end else if (pay_val) begin
			plain_error("pay_val high outside a segment");
		end
		if (seg_val) begin
			hdr_count++;
			link_owed++;
			if (in_pay) begin
				plain_error("header overlaps a payload");
			end
			if (zero_wnd) begin
				plain_error("segment sent into a zero window");
			end
			if (seg_seq != model_nxt) begin
				value_error("seg_seq", int'(seg_seq), int'(model_nxt));
			end
			if (seg_len == '0 || seg_len > `SEG_MAX) begin
				value_error("seg_len", int'(seg_len), `SEG_MAX);
			end else if (seq_t'(seg_seq + seg_len - model_una)
					> seq_t'(right_edge - model_una)) begin
				plain_error("segment runs past the window");
			end
			pay_left = int'(seg_len);
			pay_seq = seg_seq;
			model_nxt = seq_t'(seg_seq + seg_len);
		end
	endtask

	task automatic drive();
		data_t d;
		usr_val    <= 1'b0;
		ack_val    <= 1'b0;
		seg_credit <= 1'b0;
		if (user_on && user_cred > 0 && rand_bits(1) == 1) begin
			d = data_t'(rand_bits(`DATA_W));
			usr_val  <= 1'b1;
			usr_data <= d;
			model_mem[wr_model] = d;
			wr_model = seq_t'(wr_model + 1);
			user_cred--;
		end
		if (link_owed > 0 && !link_hold) begin
			if (link_wait == 0) begin
				seg_credit <= 1'b1;
				link_owed--;
				link_wait = rand_bits(3);
			end else begin
				link_wait--;
			end
		end
		if (ack_on && rand_bits(2) == 0) begin
			random_ack();
		end
	endtask

	task automatic step();
		@(posedge clk);
		monitor();
		drive();
	endtask

	task automatic timed_out(string what);
		plain_error($sformatf("timeout while waiting for %s", what));
	endtask

	// All written words sent and the link holding every credit again
	task automatic wait_idle();
		int n;
		n = 0;
		while (!(model_nxt == wr_model && pay_left == 0 && link_owed == 0)
				&& n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			timed_out("all buffered data to go out");
		end
	endtask

	task automatic end_test(string name, int err0);
		if (errors == err0) begin
			$display("PASS %s", name);
		end else begin
			$display("FAIL %s with %0d errors", name, errors - err0);
			tests_failed++;
		end
	endtask

	initial begin
		int err0;
		int h0;
		int n;
		lfsr = 32'd75503;
		for (int i = 0; i < 2**`SEQ_W; i++) begin
			model_mem[i] = '0;
		end
		rst_n = 1'b0;
		usr_val = 1'b0;
		usr_data = '0;
		ack_val = 1'b0;
		ack_seq = '0;
		ack_wnd = '0;
		seg_credit = 1'b0;
		wr_model = '0;
		model_una = '0;
		model_nxt = '0;
		sent_seq = '0;
		pay_seq = '0;
		right_edge = seq_t'(`INIT_WND);
		pay_left = 0;
		user_cred = `BUF_DEPTH;
		pulses_seen = 0;
		freed_total = 0;
		link_owed = 0;
		link_wait = 0;
		hdr_count = 0;
		errors = 0;
		tests_failed = 0;
		user_on = 0;
		ack_on = 0;
		link_hold = 0;
		zero_wnd = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Random data, acks and link credit together
		err0 = errors;
		user_on = 1;
		ack_on = 1;
		for (int i = 0; i < 600; i++) begin
			step();
		end
		user_on = 0;
		wait_idle();
		end_test("random traffic", err0);

		// Closed window holds data back until an ack opens it
		err0 = errors;
		ack_on = 0;
		step();
		send_ack(sent_seq, '0);
		user_on = 1;
		for (int i = 0; i < 60; i++) begin
			step();
		end
		user_on = 0;
		step();
		send_ack(model_una, seq_t'(`INIT_WND));
		ack_on = 1;
		wait_idle();
		end_test("zero window", err0);

		// No link credit returned for a while
		err0 = errors;
		link_hold = 1;
		h0 = hdr_count;
		user_on = 1;
		for (int i = 0; i < 100; i++) begin
			step();
		end
		if (hdr_count - h0 > `LINK_CREDITS) begin
			value_error("header count", hdr_count - h0, `LINK_CREDITS);
		end
		user_on = 0;
		link_hold = 0;
		wait_idle();
		end_test("link back-pressure", err0);

		// Acknowledge everything and wait for every user credit
		err0 = errors;
		ack_on = 0;
		step();
		send_ack(sent_seq, seq_t'(`INIT_WND));
		n = 0;
		while (user_cred != `BUF_DEPTH && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			timed_out("user credits to return");
		end
		for (int i = 0; i < 10; i++) begin
			step();
			if (usr_credit || seg_val || pay_val) begin
				plain_error("output still active after drain");
			end
		end
		end_test("drain", err0);

		$display("Tests failed %0d of 4, errors %0d, headers %0d, words %0d",
			tests_failed, errors, hdr_count, freed_total);
		if (tests_failed == 0 && errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Overall limit on the run
	initial begin
		#2000000;
		$display("Simulation ran past its time limit");
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* verilog/tcp_snd.sv */
// Top level of the windowed sender
// User side: start with BUF_DEPTH credits, one usr_val per credit
// Link side: the sender starts with LINK_CREDITS and spends one per header
// Acks have no flow control, one per cycle at most
`timescale 1ns/1ps

module tcp_snd (
	input  logic               clk,
	input  logic               rst_n,
	// User process
	input  logic               usr_val,
	input  tcp_snd_pkg::data_t usr_data,
	output logic               usr_credit,
	// Acknowledgements from the receiver
	input  logic               ack_val,
	input  tcp_snd_pkg::seq_t  ack_seq,
	input  tcp_snd_pkg::seq_t  ack_wnd,
	// Link
	output logic               seg_val,
	output tcp_snd_pkg::seq_t  seg_seq,
	output tcp_snd_pkg::len_t  seg_len,
	output logic               pay_val,
	output tcp_snd_pkg::data_t pay_data,
	input  logic               seg_credit
);
	import tcp_snd_pkg::*;

	seq_t  wr_seq;
	seq_t  snd_una;
	seq_t  rd_addr;
	data_t rd_data;

	seg_desc_if i_desc_if (
		.clk (clk)
	);

	snd_buffer i_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.usr_val    (usr_val),
		.usr_data   (usr_data),
		.usr_credit (usr_credit),
		.snd_una    (snd_una),
		.wr_seq     (wr_seq),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

	snd_window_ctrl i_window_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.ack_val   (ack_val),
		.ack_seq   (ack_seq),
		.ack_wnd   (ack_wnd),
		.wr_seq    (wr_seq),
		.snd_una   (snd_una),
		.desc_port (i_desc_if.src)
	);

	seg_emitter i_emitter (
		.clk        (clk),
		.rst_n      (rst_n),
		.desc_port  (i_desc_if.dst),
		.seg_credit (seg_credit),
		.seg_val    (seg_val),
		.seg_seq    (seg_seq),
		.seg_len    (seg_len),
		.pay_val    (pay_val),
		.pay_data   (pay_data),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

endmodule

/* verilog/seg_emitter.sv */
// Sends each queued segment as a header beat and seg_len payload beats
// Starts with LINK_CREDITS link credits and spends one per header
// Payload words come from the send buffer with one cycle of read latency
`timescale 1ns/1ps
`include "tcp_snd_settings.svh"

module seg_emitter (
	input  logic               clk,
	input  logic               rst_n,
	seg_desc_if.dst            desc_port,
	input  logic               seg_credit,
	output logic               seg_val,
	output tcp_snd_pkg::seq_t  seg_seq,
	output tcp_snd_pkg::len_t  seg_len,
	output logic               pay_val,
	output tcp_snd_pkg::data_t pay_data,
	output tcp_snd_pkg::seq_t  rd_addr,
	input  tcp_snd_pkg::data_t rd_data
);
	import tcp_snd_pkg::*;

	localparam int PTR_W = $clog2(`DESC_DEPTH);
	localparam int CNT_W = $clog2(`DESC_DEPTH + 1);
	localparam int LCR_W = $clog2(`LINK_CREDITS + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;
	typedef logic [LCR_W-1:0] lcr_t;

	seg_desc_t q_mem [`DESC_DEPTH];
	ptr_t      q_wr;
	ptr_t      q_rd;
	cnt_t      q_cnt;
	lcr_t      link_cred;

	// Buffer reads still to issue for the current segment
	len_t rd_left;
	logic pop;

	// No new header until the last read of the running segment is out
	assign pop = (q_cnt != '0) && (link_cred != '0) && (rd_left == '0);

	assign desc_port.desc_credit = pop;
	assign pay_data = rd_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q_wr      <= '0;
			q_rd      <= '0;
			q_cnt     <= '0;
			link_cred <= lcr_t'(`LINK_CREDITS);
			rd_left   <= '0;
			seg_val   <= 1'b0;
			pay_val   <= 1'b0;
		end else begin
			if (desc_port.desc_val) begin
				q_wr <= q_wr + 1'b1;
			end
			if (pop) begin
				q_rd <= q_rd + 1'b1;
			end
			q_cnt     <= q_cnt + cnt_t'(desc_port.desc_val) - cnt_t'(pop);
			link_cred <= link_cred - lcr_t'(pop) + lcr_t'(seg_credit);
			seg_val   <= pop;
			// A read issued this cycle is a payload beat next cycle
			pay_val   <= (rd_left != '0);
			if (pop) begin
				rd_left <= q_mem[q_rd].len;
			end else if (rd_left != '0) begin
				rd_left <= rd_left - 1'b1;
			end
		end
	end

	// Queue storage, header fields and buffer read address
	always_ff @(posedge clk) begin
		if (desc_port.desc_val) begin
			q_mem[q_wr] <= desc_port.desc;
		end
		if (pop) begin
			seg_seq <= q_mem[q_rd].seq;
			seg_len <= q_mem[q_rd].len;
			rd_addr <= q_mem[q_rd].seq;
		end else if (rd_left != '0) begin
			rd_addr <= rd_addr + 1'b1;
		end
	end

	// The link only returns credit for headers it has taken
	assert property (@(posedge clk) disable iff (!rst_n)
		seg_credit |-> (link_cred < `LINK_CREDITS));

	// Descriptor credits keep the queue from overflowing
	assert property (@(posedge desc_port.clk) disable iff (!rst_n)
		desc_port.desc_val |-> (q_cnt < `DESC_DEPTH));

endmodule

/* verilog/snd_window_ctrl.sv */
// Window bookkeeping and segmentation for the sender
// Acks outside snd_una..snd_nxt are dropped whole, window included
// A segment is sized against the window as it stands after this cycle's ack
`timescale 1ns/1ps
`include "tcp_snd_settings.svh"

module snd_window_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              ack_val,
	input  tcp_snd_pkg::seq_t ack_seq,
	input  tcp_snd_pkg::seq_t ack_wnd,
	input  tcp_snd_pkg::seq_t wr_seq,
	output tcp_snd_pkg::seq_t snd_una,
	seg_desc_if.src           desc_port
);
	import tcp_snd_pkg::*;

	localparam int CRED_W = $clog2(`DESC_DEPTH + 1);

	typedef logic [CRED_W-1:0] cred_t;

	seq_t      snd_nxt;
	seq_t      snd_wnd;
	cred_t     desc_cred;
	logic      desc_val_q;
	seg_desc_t desc_q;

	logic ack_ok;
	seq_t una_n;
	seq_t wnd_n;
	seq_t flight_n;
	seq_t unsent;
	seq_t room;
	seq_t seg_lim;
	len_t seg_len;
	logic issue;

	// Ack must land between snd_una and snd_nxt, modulo the sequence space
	assign ack_ok = ack_val
		&& (seq_t'(ack_seq - snd_una) <= seq_t'(snd_nxt - snd_una));

	assign una_n = ack_ok ? ack_seq : snd_una;
	assign wnd_n = ack_ok ? ack_wnd : snd_wnd;

	// Smallest of SEG_MAX, unsent words and room left in the window
	always_comb begin
		flight_n = seq_t'(snd_nxt - una_n);
		unsent   = seq_t'(wr_seq - snd_nxt);
		room     = (wnd_n > flight_n) ? seq_t'(wnd_n - flight_n) : '0;
		seg_lim  = unsent;
		if (room < seg_lim) begin
			seg_lim = room;
		end
		if (seg_lim > `SEG_MAX) begin
			seg_lim = seq_t'(`SEG_MAX);
		end
		seg_len = len_t'(seg_lim);
	end

	// At most one descriptor every other cycle, and only against a credit
	assign issue = (desc_cred != '0) && (seg_len != '0) && !desc_val_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			snd_una    <= '0;
			snd_nxt    <= '0;
			snd_wnd    <= seq_t'(`INIT_WND);
			desc_cred  <= cred_t'(`DESC_DEPTH);
			desc_val_q <= 1'b0;
		end else begin
			snd_una    <= una_n;
			snd_wnd    <= wnd_n;
			desc_val_q <= issue;
			if (issue) begin
				snd_nxt <= snd_nxt + seg_len;
			end
			desc_cred <= desc_cred - cred_t'(issue) + cred_t'(desc_port.desc_credit);
		end
	end

	// Descriptor payload
	always_ff @(posedge clk) begin
		if (issue) begin
			desc_q.seq <= snd_nxt;
			desc_q.len <= seg_len;
		end
	end

	assign desc_port.desc_val = desc_val_q;
	assign desc_port.desc     = desc_q;

	// Every descriptor is 1..SEG_MAX long and fits the window
	assert property (@(posedge clk) disable iff (!rst_n)
		desc_val_q |-> (desc_q.len inside {[1:`SEG_MAX]})
			&& (seq_t'(snd_nxt - snd_una) <= snd_wnd));

	// The emitter never returns a credit that was not spent
	assert property (@(posedge clk) disable iff (!rst_n)
		desc_port.desc_credit |-> (desc_cred < `DESC_DEPTH));

endmodule

/* verilog/snd_buffer.sv */
// Send buffer ring indexed by the low bits of the sequence number
// The user must hold a credit for every write and gets one back per freed slot
// rd_data follows rd_addr by one cycle
`timescale 1ns/1ps
`include "tcp_snd_settings.svh"

module snd_buffer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               usr_val,
	input  tcp_snd_pkg::data_t usr_data,
	output logic               usr_credit,
	input  tcp_snd_pkg::seq_t  snd_una,
	output tcp_snd_pkg::seq_t  wr_seq,
	input  tcp_snd_pkg::seq_t  rd_addr,
	output tcp_snd_pkg::data_t rd_data
);
	import tcp_snd_pkg::*;

	localparam int IDX_W = $clog2(`BUF_DEPTH);
	localparam int CNT_W = $clog2(`BUF_DEPTH) + 1;

	typedef logic [CNT_W-1:0] cnt_t;

	data_t mem [`BUF_DEPTH];

	// Last snd_una seen, and credits still owed to the user
	seq_t rel_seq;
	cnt_t cred_cnt;

	seq_t pending;
	seq_t in_use;

	// Owed credits plus whatever the current snd_una has just released
	assign pending = seq_t'(cred_cnt) + seq_t'(snd_una - rel_seq);

	// One pulse per cycle until the owed count drains
	assign usr_credit = (pending != '0);

	// Words written but not yet acknowledged
	assign in_use = seq_t'(wr_seq - snd_una);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_seq   <= '0;
			rel_seq  <= '0;
			cred_cnt <= '0;
		end else begin
			if (usr_val) begin
				wr_seq <= wr_seq + 1'b1;
			end
			rel_seq  <= snd_una;
			cred_cnt <= cnt_t'(pending - seq_t'(usr_credit));
		end
	end

	// Word storage and registered read port
	always_ff @(posedge clk) begin
		if (usr_val) begin
			mem[wr_seq[IDX_W-1:0]] <= usr_data;
		end
		rd_data <= mem[rd_addr[IDX_W-1:0]];
	end

	// User credits must keep writes off unacknowledged slots
	assert property (@(posedge clk) disable iff (!rst_n)
		usr_val |-> (in_use < `BUF_DEPTH));

	// Never owe more credits than there are slots
	assert property (@(posedge clk) disable iff (!rst_n)
		pending <= `BUF_DEPTH);

endmodule

/* verilog/seg_desc_if.sv */
// Descriptor channel from the window controller to the emitter
// The source starts with DESC_DEPTH credits and spends one per desc_val pulse
// The destination pulses desc_credit once for every descriptor it pops
`timescale 1ns/1ps

interface seg_desc_if (
	input logic clk
);
	import tcp_snd_pkg::*;

	logic      desc_val;
	seg_desc_t desc;
	logic      desc_credit;

	// Window controller side
	modport src (
		input  clk,
		output desc_val,
		output desc,
		input  desc_credit
	);

	// Emitter side
	modport dst (
		input  clk,
		input  desc_val,
		input  desc,
		output desc_credit
	);

endinterface

/* verilog/tcp_snd_pkg.sv */
// Shared types of the sender
// Sequence arithmetic is modulo 2^SEQ_W everywhere
`include "tcp_snd_settings.svh"

package tcp_snd_pkg;

	// Wide enough to hold SEG_MAX itself
	localparam int LEN_W = $clog2(`SEG_MAX + 1);

	// One sequence number, one per buffered word
	typedef logic [`SEQ_W-1:0] seq_t;

	// One payload word
	typedef logic [`DATA_W-1:0] data_t;

	// Segment length in words
	typedef logic [LEN_W-1:0] len_t;

	// Segment descriptor passed from the window controller to the emitter
	typedef struct packed {
		seq_t seq;
		len_t len;
	} seg_desc_t;

endpackage

/* include/tcp_snd_settings.svh */
// Sizing of the word-granular TCP sender
// BUF_DEPTH must be a power of two no larger than half the sequence space
// DESC_DEPTH must be a power of two of at least 2
`ifndef TCP_SND_SETTINGS_SVH
`define TCP_SND_SETTINGS_SVH

// Sequence number and payload widths
`define SEQ_W 8
`define DATA_W 8

// Send buffer slots and largest segment in words
`define BUF_DEPTH 16
`define SEG_MAX 4

// Window in force after reset, in words
`define INIT_WND 8

// Segments the link can hold after reset, and emitter queue depth
`define LINK_CREDITS 2
`define DESC_DEPTH 2

`endif
